// File: hdl/glay_setup_pkg.sv
// ---------------------------------------------------------
// Kernel setup package
// Widths, FIFO sizing and the setup FSM state type shared
// by every block of the kernel setup path
// ---------------------------------------------------------

package glay_setup_pkg;

    // ---------------------------------------------------------
    // Datapath widths
    // ---------------------------------------------------------
    // Byte address into graph memory
    localparam int addr_w = 64;

    // One cache response word
    localparam int data_w = 64;

    // Number of lines per descriptor
    localparam int count_w = 16;

    // ---------------------------------------------------------
    // Memory layout and buffering
    // ---------------------------------------------------------
    // Byte step between consecutive cache lines
    localparam int line_bytes = 64;

    // Entries in request and response FIFOs
    localparam int fifo_depth = 32;

    // Reset-busy window after reset release, in cycles
    localparam int fifo_init_cycles = 8;

    // ---------------------------------------------------------
    // Payload types
    // ---------------------------------------------------------
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [data_w-1:0]  data_t;
    typedef logic [count_w-1:0] count_t;

    // ---------------------------------------------------------
    // Setup FSM states
    // ---------------------------------------------------------
    typedef enum logic [2:0] {
        setup_kernel_reset,
        setup_kernel_idle,
        setup_kernel_req_start,
        setup_kernel_req_busy,
        setup_kernel_req_done
    } kernel_setup_state;

endpackage : glay_setup_pkg

// File: hdl/glay_setup_fifo.sv
// ---------------------------------------------------------
// Synchronous FIFO with a type-parameterized payload
// Reset-busy window after reset, registered read port with
// a valid flag, full, almost-full and empty status
// ---------------------------------------------------------
`timescale 1ns/1ns

module glay_setup_fifo #(
    parameter type payload_t = logic [63:0],
    parameter int  depth     = glay_setup_pkg::fifo_depth
) (
    input  logic     ap_clk,
    input  logic     setup_areset,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     valid,
    output logic     full,
    output logic     almost_full,
    output logic     empty,
    output logic     rst_busy
);

    // Widths derived from depth
    localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w  = $clog2(depth + 1);
    localparam int init_w = $clog2(glay_setup_pkg::fifo_init_cycles + 1);

    // ---------------------------------------------------------
    // Storage and pointers
    // ---------------------------------------------------------
    payload_t mem [depth];

    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic [init_w-1:0] init_cnt;

    logic wr_ok;
    logic rd_ok;

    // Busy window and full/empty block both ports
    assign wr_ok = wr_en && !full && !rst_busy;
    assign rd_ok = rd_en && !empty && !rst_busy;

    // Status flags straight from occupancy
    assign full        = (count == cnt_w'(depth));
    assign empty       = (count == '0);
    // Two slots left over for writes still in flight
    assign almost_full = (count >= cnt_w'(depth - 2));

    // ---------------------------------------------------------
    // Reset-busy window
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            rst_busy <= 1'b1;
            init_cnt <= '0;
        end else if (rst_busy) begin
            init_cnt <= init_cnt + 1'b1;
            // Leave busy after the last init cycle
            if (init_cnt == init_w'(glay_setup_pkg::fifo_init_cycles - 1)) begin
                rst_busy <= 1'b0;
            end
        end
    end

    // ---------------------------------------------------------
    // Pointer and occupancy control
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : glay_setup_fifo

// File: hdl/glay_setup_req_gen.sv
// ---------------------------------------------------------
// Setup request generator
// FSM that walks one descriptor and pushes a cache line
// address per cycle into the request FIFO
// ---------------------------------------------------------
`timescale 1ns/1ns

module glay_setup_req_gen (
    input  logic                   ap_clk,
    input  logic                   setup_areset,
    input  logic                   start,
    input  glay_setup_pkg::addr_t  base,
    input  glay_setup_pkg::count_t lines,
    input  logic                   fifo_almost_full,
    output logic                   fifo_wr_en,
    output glay_setup_pkg::addr_t  fifo_din,
    output logic                   busy,
    output glay_setup_pkg::count_t run_lines
);

    // ---------------------------------------------------------
    // FSM and run state
    // ---------------------------------------------------------
    glay_setup_pkg::kernel_setup_state current_state;
    glay_setup_pkg::kernel_setup_state next_state;

    // Descriptor latched on start
    glay_setup_pkg::addr_t  base_q;
    glay_setup_pkg::count_t lines_q;

    // Index of the next line to request
    glay_setup_pkg::count_t line_idx;

    logic setup_complete;
    logic issue;

    // All lines of the run written
    assign setup_complete = (line_idx == lines_q);

    // One write per cycle unless the FIFO is nearly full
    assign issue = (current_state == glay_setup_pkg::setup_kernel_req_busy) &&
                   !setup_complete && !fifo_almost_full;

    assign busy      = (current_state != glay_setup_pkg::setup_kernel_idle);
    assign run_lines = lines_q;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            current_state <= glay_setup_pkg::setup_kernel_reset;
        end else begin
            current_state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = current_state;
        case (current_state)
            glay_setup_pkg::setup_kernel_reset: begin
                next_state = glay_setup_pkg::setup_kernel_idle;
            end
            glay_setup_pkg::setup_kernel_idle: begin
                if (start) begin
                    next_state = glay_setup_pkg::setup_kernel_req_start;
                end
            end
            glay_setup_pkg::setup_kernel_req_start: begin
                next_state = glay_setup_pkg::setup_kernel_req_busy;
            end
            glay_setup_pkg::setup_kernel_req_busy: begin
                // Zero-line runs fall straight through
                if (setup_complete) begin
                    next_state = glay_setup_pkg::setup_kernel_req_done;
                end
            end
            glay_setup_pkg::setup_kernel_req_done: begin
                next_state = glay_setup_pkg::setup_kernel_idle;
            end
            default: begin
                next_state = glay_setup_pkg::setup_kernel_reset;
            end
        endcase
    end

    // ---------------------------------------------------------
    // Line counter and FIFO write strobe
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            line_idx   <= '0;
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= issue;
            if (current_state == glay_setup_pkg::setup_kernel_req_start) begin
                line_idx <= '0;
            end else if (issue) begin
                line_idx <= line_idx + 1'b1;
            end
        end
    end

    // Descriptor capture and line address
    always_ff @(posedge ap_clk) begin
        if (start && current_state == glay_setup_pkg::setup_kernel_idle) begin
            base_q  <= base;
            lines_q <= lines;
        end
        if (issue) begin
            fifo_din <= base_q + glay_setup_pkg::addr_t'(line_idx) *
                        glay_setup_pkg::addr_t'(glay_setup_pkg::line_bytes);
        end
    end

endmodule : glay_setup_req_gen

// File: hdl/glay_setup_resp_tracker.sv
// ---------------------------------------------------------
// Setup response tracker
// Drains the response FIFO to the PEs, counts delivered
// lines and pulses done at the end of each run
// ---------------------------------------------------------
`timescale 1ns/1ns

module glay_setup_resp_tracker (
    input  logic                   ap_clk,
    input  logic                   setup_areset,
    input  logic                   run_start,
    input  glay_setup_pkg::count_t run_lines,
    input  logic                   fifo_empty,
    input  logic                   fifo_valid,
    input  glay_setup_pkg::data_t  fifo_dout,
    output logic                   fifo_rd_en,
    output logic                   data_valid,
    output glay_setup_pkg::data_t  data,
    output logic                   done
);

    // Lines delivered in the current run
    glay_setup_pkg::count_t line_cnt;

    // Run open, waiting for its last line
    logic run_active;
    logic run_complete;

    // No back-pressure, pop whenever something is there
    assign fifo_rd_en = !fifo_empty;

    // run_lines is valid from the cycle after run_start
    assign run_complete = run_active && (line_cnt == run_lines);

    // ---------------------------------------------------------
    // Line count and done pulse
    // ---------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            run_active <= 1'b0;
            line_cnt   <= '0;
            done       <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= fifo_valid;
            done       <= run_complete;
            if (run_start) begin
                run_active <= 1'b1;
            end else if (run_complete) begin
                run_active <= 1'b0;
            end
            // Clear on completion, count every popped word otherwise
            if (run_complete) begin
                line_cnt <= '0;
            end else if (fifo_valid) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // Setup data toward the PEs
    always_ff @(posedge ap_clk) begin
        if (fifo_valid) begin
            data <= fifo_dout;
        end
    end

endmodule : glay_setup_resp_tracker

// File: hdl/glay_kernel_setup.sv
// ---------------------------------------------------------
// Kernel setup top level
// Registers the descriptor and cache ports, buffers cache
// requests and responses, and gates runs on FIFO readiness
// ---------------------------------------------------------
`timescale 1ns/1ns

module glay_kernel_setup (
    input  logic                   ap_clk,
    input  logic                   setup_areset,
    // Graph descriptor
    input  logic                   descriptor_valid,
    input  glay_setup_pkg::addr_t  descriptor_base,
    input  glay_setup_pkg::count_t descriptor_lines,
    // Cache request port
    input  logic                   cache_req_stall,
    output logic                   cache_req_valid,
    output glay_setup_pkg::addr_t  cache_req_addr,
    // Cache response port
    input  logic                   cache_resp_valid,
    input  glay_setup_pkg::data_t  cache_resp_data,
    // Toward the processing elements
    output logic                   setup_data_valid,
    output glay_setup_pkg::data_t  setup_data,
    output logic                   setup_done,
    output logic                   fifo_setup_signal
);

    // ---------------------------------------------------------
    // Registered inputs
    // ---------------------------------------------------------
    logic                   descriptor_valid_q;
    glay_setup_pkg::addr_t  descriptor_base_q;
    glay_setup_pkg::count_t descriptor_lines_q;
    logic                   cache_req_stall_q;
    logic                   cache_resp_valid_q;
    glay_setup_pkg::data_t  cache_resp_data_q;

    // Generator and tracker handshake
    logic                   run_start;
    logic                   run_open;
    logic                   gen_busy;
    glay_setup_pkg::count_t run_lines;

    // Request FIFO
    logic                   req_wr_en;
    glay_setup_pkg::addr_t  req_din;
    logic                   req_rd_en;
    glay_setup_pkg::addr_t  req_dout;
    logic                   req_valid;
    logic                   req_almost_full;
    logic                   req_empty;
    logic                   req_rst_busy;

    // Response FIFO
    logic                   resp_rd_en;
    glay_setup_pkg::data_t  resp_dout;
    logic                   resp_valid;
    logic                   resp_empty;
    logic                   resp_rst_busy;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            descriptor_valid_q <= 1'b0;
            cache_req_stall_q  <= 1'b0;
            cache_resp_valid_q <= 1'b0;
        end else begin
            descriptor_valid_q <= descriptor_valid;
            cache_req_stall_q  <= cache_req_stall;
            cache_resp_valid_q <= cache_resp_valid;
        end
    end

    // Descriptor and response payload registers
    always_ff @(posedge ap_clk) begin
        descriptor_base_q  <= descriptor_base;
        descriptor_lines_q <= descriptor_lines;
        cache_resp_data_q  <= cache_resp_data;
    end

    // ---------------------------------------------------------
    // Run gating
    // ---------------------------------------------------------
    // Descriptors outside an idle, ready window are dropped
    assign run_start = descriptor_valid_q && !gen_busy && !run_open && !fifo_setup_signal;

    // One run in flight, closed by the tracker's done
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            run_open <= 1'b0;
        end else if (run_start) begin
            run_open <= 1'b1;
        end else if (setup_done) begin
            run_open <= 1'b0;
        end
    end

    // ---------------------------------------------------------
    // Registered outputs and FIFO readiness
    // ---------------------------------------------------------
    // Drain requests unless the cache is stalling
    assign req_rd_en = !req_empty && !cache_req_stall_q;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            fifo_setup_signal <= 1'b1;
            cache_req_valid   <= 1'b0;
        end else begin
            fifo_setup_signal <= req_rst_busy | resp_rst_busy;
            cache_req_valid   <= req_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        cache_req_addr <= req_dout;
    end

    // ---------------------------------------------------------
    // Request path
    // ---------------------------------------------------------
    glay_setup_req_gen req_gen_inst (
        .ap_clk           (ap_clk),
        .setup_areset     (setup_areset),
        .start            (run_start),
        .base             (descriptor_base_q),
        .lines            (descriptor_lines_q),
        .fifo_almost_full (req_almost_full),
        .fifo_wr_en       (req_wr_en),
        .fifo_din         (req_din),
        .busy             (gen_busy),
        .run_lines        (run_lines)
    );

    glay_setup_fifo #(
        .payload_t (glay_setup_pkg::addr_t),
        .depth     (glay_setup_pkg::fifo_depth)
    ) req_fifo_inst (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (req_wr_en),
        .din          (req_din),
        .rd_en        (req_rd_en),
        .dout         (req_dout),
        .valid        (req_valid),
        .full         (),
        .almost_full  (req_almost_full),
        .empty        (req_empty),
        .rst_busy     (req_rst_busy)
    );

    // ---------------------------------------------------------
    // Response path
    // ---------------------------------------------------------
    glay_setup_fifo #(
        .payload_t (glay_setup_pkg::data_t),
        .depth     (glay_setup_pkg::fifo_depth)
    ) resp_fifo_inst (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (cache_resp_valid_q),
        .din          (cache_resp_data_q),
        .rd_en        (resp_rd_en),
        .dout         (resp_dout),
        .valid        (resp_valid),
        .full         (),
        .almost_full  (),
        .empty        (resp_empty),
        .rst_busy     (resp_rst_busy)
    );

    glay_setup_resp_tracker resp_tracker_inst (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .run_start    (run_start),
        .run_lines    (run_lines),
        .fifo_empty   (resp_empty),
        .fifo_valid   (resp_valid),
        .fifo_dout    (resp_dout),
        .fifo_rd_en   (resp_rd_en),
        .data_valid   (setup_data_valid),
        .data         (setup_data),
        .done         (setup_done)
    );

endmodule : glay_kernel_setup

// File: test/glay_kernel_setup_checker.sv
// ---------------------------------------------------------
// Kernel setup checker
// Concurrent assertions on the top level strobes and levels
// ---------------------------------------------------------
`timescale 1ns/1ns

module glay_kernel_setup_checker (
    input logic ap_clk,
    input logic setup_areset,
    input logic cache_req_stall_q,
    input logic cache_req_valid,
    input logic fifo_setup_signal,
    input logic setup_done,
    input logic setup_data_valid
);

    // No requests while the FIFOs are still initializing
    assert property (@(posedge ap_clk) disable iff (setup_areset)
        fifo_setup_signal |-> !cache_req_valid)
        else $error("cache request issued during FIFO init");

    // FIFO valid and output register sit two stages behind the stall register
    assert property (@(posedge ap_clk) disable iff (setup_areset)
        cache_req_stall_q |-> ##2 !cache_req_valid)
        else $error("cache request issued under stall");

    // Done is a single-cycle pulse
    assert property (@(posedge ap_clk) disable iff (setup_areset)
        setup_done |=> !setup_done)
        else $error("setup_done held for two cycles");

    // Quiet outputs right after reset release
    assert property (@(posedge ap_clk)
        $fell(setup_areset) |=> (!setup_done && !setup_data_valid))
        else $error("setup outputs active after reset");

endmodule : glay_kernel_setup_checker

bind glay_kernel_setup glay_kernel_setup_checker checker_inst (
    .ap_clk            (ap_clk),
    .setup_areset      (setup_areset),
    .cache_req_stall_q (cache_req_stall_q),
    .cache_req_valid   (cache_req_valid),
    .fifo_setup_signal (fifo_setup_signal),
    .setup_done        (setup_done),
    .setup_data_valid  (setup_data_valid)
);

// File: test/glay_kernel_setup_tb.sv
// ---------------------------------------------------------
// Kernel setup testbench
// Directed tests with a cache model, a scoreboard of
// request addresses and setup words, and a watchdog
// ---------------------------------------------------------
`timescale 1ns/1ns

module glay_kernel_setup_tb;

    localparam int clk_period      = 100;
    // 5 + 30 + 8 + 1 + 32 + 0 lines over all tests
    localparam int total_lines     = 76;
    localparam int watchdog_cycles = total_lines * 20 + 500;

    logic                   ap_clk;
    logic                   setup_areset;
    logic                   descriptor_valid;
    glay_setup_pkg::addr_t  descriptor_base;
    glay_setup_pkg::count_t descriptor_lines;
    logic                   cache_req_stall;
    logic                   cache_req_valid;
    glay_setup_pkg::addr_t  cache_req_addr;
    logic                   cache_resp_valid;
    glay_setup_pkg::data_t  cache_resp_data;
    logic                   setup_data_valid;
    glay_setup_pkg::data_t  setup_data;
    logic                   setup_done;
    logic                   fifo_setup_signal;

    // Scoreboards and cache model state
    glay_setup_pkg::addr_t exp_addr [$];
    glay_setup_pkg::data_t exp_data [$];
    glay_setup_pkg::addr_t pending [$];
    int                    req_count  = 0;
    int                    done_count = 0;
    logic [63:0]           rng_state  = 64'd31;

    glay_kernel_setup UUT (
        .ap_clk            (ap_clk),
        .setup_areset      (setup_areset),
        .descriptor_valid  (descriptor_valid),
        .descriptor_base   (descriptor_base),
        .descriptor_lines  (descriptor_lines),
        .cache_req_stall   (cache_req_stall),
        .cache_req_valid   (cache_req_valid),
        .cache_req_addr    (cache_req_addr),
        .cache_resp_valid  (cache_resp_valid),
        .cache_resp_data   (cache_resp_data),
        .setup_data_valid  (setup_data_valid),
        .setup_data        (setup_data),
        .setup_done        (setup_done),
        .fifo_setup_signal (fifo_setup_signal)
    );

    initial begin : clock_gen
        ap_clk = 1'b0;
        forever #(clk_period / 2) ap_clk = ~ap_clk;
    end

    // ---------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------
    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge ap_clk);
    endtask

    // One-cycle descriptor, optionally with its expected addresses and data
    task automatic send_descriptor(input glay_setup_pkg::addr_t base, input int lines,
                                   input bit expect_run);
        glay_setup_pkg::addr_t addr;
        if (expect_run) begin
            for (int i = 0; i < lines; i++) begin
                addr = base + glay_setup_pkg::addr_t'(i * glay_setup_pkg::line_bytes);
                exp_addr.push_back(addr);
                exp_data.push_back(xorshift(addr));
            end
        end
        @(negedge ap_clk);
        descriptor_valid = 1'b1;
        descriptor_base  = base;
        descriptor_lines = lines[15:0];
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
    endtask

    task automatic wait_done(input int target, input int max_cycles);
        int waited;
        waited = 0;
        while (done_count < target && waited < max_cycles) begin
            @(negedge ap_clk);
            waited++;
        end
        if (done_count < target) fail_run("setup_done did not arrive");
    endtask

    task automatic wait_requests(input int target, input int max_cycles);
        int waited;
        waited = 0;
        while (req_count < target && waited < max_cycles) begin
            @(negedge ap_clk);
            waited++;
        end
        if (req_count < target) fail_run("cache requests did not appear");
    endtask

    // Full run with request and done counts
    task automatic run_descriptor(input glay_setup_pkg::addr_t base, input int lines);
        int req_start;
        int done_start;
        req_start  = req_count;
        done_start = done_count;
        send_descriptor(base, lines, 1'b1);
        wait_done(done_start + 1, lines * 20 + 100);
        settle(10);
        check_value("request count", 64'(req_count - req_start), 64'(lines));
        check_value("done count", 64'(done_count - done_start), 64'd1);
    endtask

    // ---------------------------------------------------------
    // Directed tests
    // ---------------------------------------------------------
    task automatic test_reset_init();
        int waited;
        setup_areset = 1'b1;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        setup_areset = 1'b0;
        check_value("cache_req_valid", 64'(cache_req_valid), 64'd0);
        check_value("setup_data_valid", 64'(setup_data_valid), 64'd0);
        check_value("setup_done", 64'(setup_done), 64'd0);
        check_value("fifo_setup_signal", 64'(fifo_setup_signal), 64'd1);
        // Descriptor in the last cycle of FIFO init, to be dropped
        descriptor_base  = 64'h1000;
        descriptor_lines = 16'd3;
        waited = 0;
        while (fifo_setup_signal && waited < glay_setup_pkg::fifo_init_cycles + 2) begin
            @(negedge ap_clk);
            waited++;
            descriptor_valid = (waited == glay_setup_pkg::fifo_init_cycles - 1);
        end
        descriptor_valid = 1'b0;
        if (fifo_setup_signal) fail_run("fifo_setup_signal stayed high after reset");
        settle(12);
        check_value("request count", 64'(req_count), 64'd0);
        check_value("done count", 64'(done_count), 64'd0);
    endtask

    task automatic test_single_run();
        run_descriptor(64'h0010_0000, 5);
    endtask

    task automatic test_stall();
        int done_start;
        int held;
        done_start = done_count;
        send_descriptor(64'h0020_0000, 30, 1'b1);
        wait_requests(req_count + 1, 100);
        cache_req_stall = 1'b1;
        // Requests already in the output pipeline drain first
        settle(3);
        held = req_count;
        settle(37);
        check_value("requests under stall", 64'(req_count), 64'(held));
        cache_req_stall = 1'b0;
        wait_done(done_start + 1, 30 * 20);
        settle(10);
        check_value("done count", 64'(done_count - done_start), 64'd1);
    endtask

    task automatic test_busy_drop();
        int req_start;
        int done_start;
        req_start  = req_count;
        done_start = done_count;
        send_descriptor(64'h0030_0000, 8, 1'b1);
        wait_requests(req_start + 1, 100);
        // Second descriptor mid-run, nothing expected from it
        send_descriptor(64'h0040_0000, 4, 1'b0);
        wait_done(done_start + 1, 8 * 20 + 100);
        settle(30);
        check_value("request count", 64'(req_count - req_start), 64'd8);
        check_value("done count", 64'(done_count - done_start), 64'd1);
    endtask

    task automatic test_runs();
        run_descriptor(64'h0050_0000, 1);
        run_descriptor(64'h0060_0000, 32);
        run_descriptor(64'h0070_0000, 0);
    endtask

    // ---------------------------------------------------------
    // Cache model, monitors and watchdog
    // ---------------------------------------------------------
    // In-order responses after 0 to 3 idle cycles, held under stall
    initial begin : cache_model
        int gap;
        gap              = 0;
        cache_resp_valid = 1'b0;
        cache_resp_data  = '0;
        forever begin
            @(negedge ap_clk);
            cache_resp_valid = 1'b0;
            if (cache_req_valid === 1'b1) pending.push_back(cache_req_addr);
            if (gap > 0) begin
                gap--;
            end else if (pending.size() > 0 && !cache_req_stall) begin
                cache_resp_valid = 1'b1;
                cache_resp_data  = xorshift(pending.pop_front());
                rng_state        = xorshift(rng_state);
                gap              = int'(rng_state[1:0]);
            end
        end
    end

    initial begin : output_monitor
        forever begin
            @(negedge ap_clk);
            if (cache_req_valid === 1'b1) begin
                req_count++;
                if (exp_addr.size() == 0) fail_run("Unexpected cache request");
                else check_value("cache_req_addr", cache_req_addr, exp_addr.pop_front());
            end
            if (setup_data_valid === 1'b1) begin
                if (exp_data.size() == 0) fail_run("Unexpected setup data word");
                else check_value("setup_data", setup_data, exp_data.pop_front());
            end
            if (setup_done === 1'b1) begin
                done_count++;
                if (exp_data.size() != 0) fail_run("setup_done before all setup data");
            end
        end
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        fail_run("Timeout, the tests did not finish in time");
    end

    initial begin : main
        setup_areset     = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        descriptor_lines = '0;
        cache_req_stall  = 1'b0;
        test_reset_init();
        test_single_run();
        test_stall();
        test_busy_drop();
        test_runs();
        settle(20);
        if (exp_addr.size() != 0 || exp_data.size() != 0) begin
            fail_run("Scoreboard entries left over at end of run");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule : glay_kernel_setup_tb

// File: glay_kernel_setup.f
hdl/glay_setup_pkg.sv
hdl/glay_setup_fifo.sv
hdl/glay_setup_req_gen.sv
hdl/glay_setup_resp_tracker.sv
hdl/glay_kernel_setup.sv
test/glay_kernel_setup_checker.sv
test/glay_kernel_setup_tb.sv
